/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build folder"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module fetch_tb -o fetch_sim
	@out="$$(./obj_dir/fetch_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* bench/fetch_mem_model.sv */
`timescale 1ns/100ps

module fetch_mem_model (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_i,
  input  fetch_pkg::addr_t  addr_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output fetch_pkg::instr_t rdata_o
);
  import fetch_pkg::*;

  // 16 KB of instruction words, indexed by addr[13:2]
  instr_t mem [4096];

  // granted addresses waiting for their response
  addr_t  pend_q [$];
  addr_t  resp_addr;
  logic   granted;
  int     gnt_wait;
  int     resp_wait;

  // used by the testbench to fill the image
  task automatic write_word(input int unsigned idx, input instr_t w);
    mem[idx % 4096] = w;
  endtask

  // ------------------------------
  // bus process
  // ------------------------------
  // outputs change on the falling edge, DUT samples on the rising edge
  initial begin
    gnt_o     = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    granted   = 1'b0;
    gnt_wait  = 0;
    resp_wait = 0;
    forever begin
      @(posedge clk);
      // a grant happens when req and gnt are both high at the edge
      if (rst_n && req_i && gnt_o) begin
        pend_q.push_back(addr_i);
        granted = 1'b1;
      end
      @(negedge clk);
      if (!rst_n) begin
        gnt_o     = 1'b0;
        rvalid_o  = 1'b0;
        granted   = 1'b0;
        gnt_wait  = 0;
        resp_wait = 0;
        pend_q.delete();
      end else begin
        // new random grant delay after every grant
        if (granted) begin
          gnt_wait = $urandom % 4;
          granted  = 1'b0;
        end
        if (req_i && (gnt_wait == 0)) begin
          gnt_o = 1'b1;
        end else begin
          gnt_o = 1'b0;
          if (req_i && (gnt_wait > 0)) gnt_wait--;
        end
        // in order responses, one per grant
        rvalid_o = 1'b0;
        if (pend_q.size() > 0) begin
          if (resp_wait == 0) begin
            resp_addr = pend_q.pop_front();
            rvalid_o  = 1'b1;
            rdata_o   = mem[resp_addr[13:2]];
            resp_wait = $urandom % 4;
          end else begin
            resp_wait--;
          end
        end
      end
    end
  end

endmodule

/* bench/fetch_tb.sv */
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_tb;
  import fetch_pkg::*;

  // entries checked per test
  localparam int N_BOOT  = 16;
  localparam int N_MIX   = 40;
  localparam int N_PRE   = 4;
  localparam int N_JMP   = 16;
  localparam int N_VEC   = 6;
  localparam int N_STALL = 150;
  localparam int N_ILL   = 12;
  localparam int N_TOTAL = N_BOOT + N_MIX + N_PRE + N_JMP + 5 * N_VEC + N_STALL + N_ILL;

  logic      clk;
  logic      rst_n;
  logic      fetch_en_i;
  redirect_t redirect_i;
  trap_cfg_t trap_cfg_i;
  logic      instr_req_o;
  addr_t     instr_addr_o;
  logic      instr_gnt_i;
  logic      instr_rvalid_i;
  instr_t    instr_rdata_i;
  logic      instr_valid_o;
  if_id_t    if_id_o;
  logic      id_ready_i;

  instr_t    image [4096];
  if_id_t    exp_q [$];
  int        err_cnt;
  int        test_cnt;
  int        fail_cnt;
  int        test_err0;
  string     cur_name;
  // granted requests still waiting for rvalid
  int        in_flight;

  fetch_top fetch_top_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_en_i     (fetch_en_i),
    .redirect_i     (redirect_i),
    .trap_cfg_i     (trap_cfg_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_valid_o  (instr_valid_o),
    .if_id_o        (if_id_o),
    .id_ready_i     (id_ready_i)
  );

  fetch_mem_model mem_model_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------
  // instruction encoders
  // ------------------------------
  function automatic instr_t enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                   logic [4:0] rd, logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3, logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  function automatic instr_t enc_b(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic instr_t enc_j(logic [31:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic instr_t enc_r(logic [4:0] rs2, logic [4:0] rs1, logic [4:0] rd);
    return {7'd0, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------
  // 32-bit form of a supported 16-bit encoding
  function automatic instr_t expand_ref(input logic [15:0] c, output logic ill);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs1p;
    logic [31:0] imm6;
    logic [31:0] uoff;
    logic [31:0] jimm;
    logic [31:0] bimm;
    instr_t      r;
    rd   = c[11:7];
    rs2  = c[6:2];
    rdp  = 5'd8 + c[4:2];
    rs1p = 5'd8 + c[9:7];
    imm6 = {{26{c[12]}}, c[12], c[6:2]};
    uoff = {25'd0, c[5], c[12:10], c[6], 2'b00};
    jimm = {{21{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    bimm = {{24{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    r    = '0;
    ill  = 1'b0;
    case ({c[1:0], c[15:13]})
      5'b00_010: r = enc_i(uoff, rs1p, 3'b010, rdp, 7'h03);
      5'b00_110: r = enc_s(uoff, rdp, rs1p, 3'b010, 7'h23);
      5'b01_000: r = enc_i(imm6, rd, 3'b000, rd, 7'h13);
      5'b01_001: r = enc_j(jimm, 5'd1);
      5'b01_101: r = enc_j(jimm, 5'd0);
      5'b01_010: r = enc_i(imm6, 5'd0, 3'b000, rd, 7'h13);
      5'b01_011: begin
        // rd 2 would be c.addi16sp
        if ((rd == 5'd2) || (imm6 == 32'd0)) ill = 1'b1;
        else r = {imm6[19:0], rd, 7'h37};
      end
      5'b01_110: r = enc_b(bimm, rs1p, 3'b000);
      5'b01_111: r = enc_b(bimm, rs1p, 3'b001);
      5'b10_100: begin
        if (rs2 != 5'd0) r = enc_r(rs2, c[12] ? rd : 5'd0, rd);
        else if (rd == 5'd0) ill = 1'b1;
        else r = enc_i(32'd0, rd, 3'b000, c[12] ? 5'd1 : 5'd0, 7'h67);
      end
      default: ill = 1'b1;
    endcase
    return r;
  endfunction

  function automatic logic [15:0] half_at(addr_t a);
    instr_t w;
    w = image[a[13:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // entry that decode should see at pc in the image walk
  function automatic if_id_t next_expected(addr_t pc);
    if_id_t      e;
    logic [15:0] lo;
    logic        ill;
    lo = half_at(pc);
    e.pc = pc;
    if (lo[1:0] == 2'b11) begin
      e.instr         = {half_at(pc + 32'd2), lo};
      e.is_compressed = 1'b0;
      e.illegal_c     = 1'b0;
    end else begin
      e.instr         = expand_ref(lo, ill);
      e.is_compressed = 1'b1;
      e.illegal_c     = ill;
    end
    return e;
  endfunction

  // first pc after a redirect
  function automatic addr_t vector_ref(redirect_t r, trap_cfg_t t);
    case (r.pc_sel)
      PC_JUMP:   return r.jump_target & ~32'd1;
      PC_BRANCH: return r.branch_target & ~32'd1;
      PC_MRET:   return r.mepc & ~32'd1;
      PC_DRET:   return r.depc & ~32'd1;
      PC_EXCEPTION: begin
        if (r.exc_sel == EXC_IRQ) return ({8'd0, t.trap_base} << 8) + (32'(r.irq_id) << 2);
        if (r.exc_sel == EXC_DEBUG) return {t.dm_halt_addr, 2'b00};
        return {8'd0, t.trap_base} << 8;
      end
      default:   return `FETCH_BOOT_ADDR;
    endcase
  endfunction

  // ------------------------------
  // checking
  // ------------------------------
  task automatic check(input logic [65:0] exp_v, input logic [65:0] act_v);
    if (exp_v !== act_v) begin
      $display("mismatch %s expected %h actual %h", cur_name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  // every transfer on the decode port
  always @(posedge clk) begin
    if (rst_n && instr_valid_o && id_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("%s: decode took an entry at pc %h that was not expected",
                 cur_name, if_id_o.pc);
        err_cnt++;
      end else begin
        check(exp_q.pop_front(), if_id_o);
      end
    end
  end

  // memory side bookkeeping, one rvalid per grant
  always @(posedge clk) begin
    if (!rst_n) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(instr_req_o && instr_gnt_i) - int'(instr_rvalid_i);
    end
  end

  initial begin
    repeat (N_TOTAL * 40 + 8) @(posedge clk);
    $display("timeout in %s with %0d entries never delivered", cur_name, exp_q.size());
    $display("Test FAILED");
    $finish;
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  task automatic fill_words(int base, int n, bit mixed);
    for (int k = 0; k < n; k++) begin
      // random halfwords give a natural mix of 16 and 32 bit parcels
      image[base + k] = mixed ? $urandom : ($urandom | 32'h3);
    end
  endtask

  task automatic set_half(addr_t a, logic [15:0] h);
    if (a[1]) image[a[13:2]][31:16] = h;
    else image[a[13:2]][15:0] = h;
  endtask

  task automatic build_image();
    logic [15:0] ill_list [12];
    ill_list = '{16'h0000, 16'h8001, 16'h6101, 16'h8002, 16'h4002, 16'h2000,
                 16'h9c01, 16'he000, 16'h6002, 16'hc002, 16'h0002, 16'h7101};
    for (int i = 0; i < 4096; i++) image[i] = (i * 32'h9e37_79b9) ^ 32'h00c0_ffee;
    fill_words(`FETCH_BOOT_ADDR >> 2, 64, 1'b0);
    fill_words(32'h400 >> 2, 64, 1'b1);
    fill_words(32'h800 >> 2, 64, 1'b1);
    fill_words(32'hc00 >> 2, 64, 1'b0);
    // trap table, debug and return targets
    fill_words(32'h1000 >> 2, 32'h600, 1'b1);
    fill_words(32'h3000 >> 2, 256, 1'b1);
    for (int k = 0; k < N_ILL; k++) set_half(32'h3800 + 2 * k, ill_list[k]);
    for (int i = 0; i < 4096; i++) mem_model_i.write_word(i, image[i]);
  endtask

  task automatic load_expected(addr_t start, int n);
    addr_t  pc;
    if_id_t e;
    pc = start;
    for (int k = 0; k < n; k++) begin
      e = next_expected(pc);
      exp_q.push_back(e);
      pc = pc + (e.is_compressed ? 32'd2 : 32'd4);
    end
  endtask

  function automatic redirect_t make_redirect(pc_sel_e sel, exc_sel_e exc, addr_t tgt);
    redirect_t r;
    r.pc_set        = 1'b1;
    r.pc_sel        = sel;
    r.exc_sel       = exc;
    r.irq_id        = 5'd5;
    // the unselected target points at other code
    r.jump_target   = (sel == PC_JUMP) ? tgt : 32'h0000_0e00;
    r.branch_target = (sel == PC_BRANCH) ? tgt : 32'h0000_0a00;
    r.mepc          = 32'h2002;
    r.depc          = 32'h2403;
    return r;
  endfunction

  task automatic start_stream(redirect_t r, int n);
    load_expected(vector_ref(r, trap_cfg_i), n);
    @(negedge clk);
    redirect_i = r;
    @(negedge clk);
    redirect_i.pc_set = 1'b0;
  endtask

  // redirect only once a granted request still waits for rvalid
  task automatic redirect_in_flight(redirect_t r, int n);
    int waited;
    load_expected(vector_ref(r, trap_cfg_i), n);
    waited = 0;
    @(negedge clk);
    while ((in_flight == 0) && (waited < 8)) begin
      @(negedge clk);
      waited++;
    end
    if (in_flight == 0) begin
      $display("%s: no memory request was in flight when the redirect was issued", cur_name);
      err_cnt++;
    end
    redirect_i = r;
    @(negedge clk);
    redirect_i.pc_set = 1'b0;
  endtask

  // decode accepts until every expected entry is through
  task automatic run_ready(bit rnd);
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      if (exp_q.size() == 0) begin
        id_ready_i = 1'b0;
        busy       = 1'b0;
      end else begin
        id_ready_i = rnd ? 1'($urandom % 2) : 1'b1;
      end
    end
  endtask

  task automatic start_test(string name);
    cur_name  = name;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    if (err_cnt == test_err0) begin
      $display("test %-10s passed", cur_name);
    end else begin
      fail_cnt++;
      $display("test %-10s failed with %0d errors", cur_name, err_cnt - test_err0);
    end
  endtask

  task automatic run_vector(string name, pc_sel_e sel, exc_sel_e exc);
    start_test(name);
    start_stream(make_redirect(sel, exc, 32'h0), N_VEC);
    run_ready(1'b0);
    end_test();
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    void'($urandom(32'h3ece));
    rst_n      = 1'b0;
    fetch_en_i = 1'b0;
    redirect_i = '0;
    trap_cfg_i = '{trap_base: 24'h000010, dm_halt_addr: 30'h600};
    id_ready_i = 1'b0;
    err_cnt    = 0;
    test_cnt   = 0;
    fail_cnt   = 0;
    cur_name   = "reset";
    build_image();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test("boot");
    // no request and nothing towards decode while idle after reset
    check({64'd0, 2'b00}, {64'd0, instr_req_o, instr_valid_o});
    load_expected(`FETCH_BOOT_ADDR, N_BOOT);
    @(negedge clk);
    fetch_en_i = 1'b1;
    run_ready(1'b0);
    end_test();

    start_test("mixed");
    start_stream(make_redirect(PC_BRANCH, EXC_TRAP, 32'h400), N_MIX);
    run_ready(1'b0);
    end_test();

    // stop a running stream and jump while requests are in flight
    start_test("jump");
    start_stream(make_redirect(PC_BRANCH, EXC_TRAP, 32'h802), N_PRE);
    run_ready(1'b0);
    redirect_in_flight(make_redirect(PC_JUMP, EXC_TRAP, 32'hc00), N_JMP);
    run_ready(1'b0);
    end_test();

    run_vector("exc_trap", PC_EXCEPTION, EXC_TRAP);
    run_vector("exc_irq", PC_EXCEPTION, EXC_IRQ);
    run_vector("exc_debug", PC_EXCEPTION, EXC_DEBUG);
    run_vector("mret", PC_MRET, EXC_TRAP);
    run_vector("dret", PC_DRET, EXC_TRAP);

    start_test("stall");
    start_stream(make_redirect(PC_JUMP, EXC_TRAP, 32'h3000), N_STALL);
    run_ready(1'b1);
    end_test();

    start_test("illegal");
    start_stream(make_redirect(PC_JUMP, EXC_TRAP, 32'h3800), N_ILL);
    run_ready(1'b1);
    end_test();

    $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if ((err_cnt == 0) && (fail_cnt == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* design/fetch_pkg.sv */
package fetch_pkg;

  // ------------------------------
  // plain vector types
  // ------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  // upper bits of the handler table
  typedef logic [23:0] trap_base_t;
  typedef logic [4:0]  irq_id_t;

  // ------------------------------
  // selects and states
  // ------------------------------
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_MRET      = 3'd4,
    PC_DRET      = 3'd5
  } pc_sel_e;

  typedef enum logic [1:0] {
    EXC_TRAP  = 2'd0,
    EXC_IRQ   = 2'd1,
    EXC_DEBUG = 2'd2
  } exc_sel_e;

  typedef enum logic {
    FS_IDLE = 1'b0,
    FS_RUN  = 1'b1
  } fetch_state_e;

  // ------------------------------
  // grouped signals
  // ------------------------------
  // redirect request from the core controller
  typedef struct packed {
    logic     pc_set;
    pc_sel_e  pc_sel;
    exc_sel_e exc_sel;
    irq_id_t  irq_id;
    addr_t    jump_target;
    addr_t    branch_target;
    addr_t    mepc;
    addr_t    depc;
  } redirect_t;

  typedef struct packed {
    trap_base_t  trap_base;
    logic [29:0] dm_halt_addr;
  } trap_cfg_t;

  // raw parcel at one pc, upper half unused when compressed
  typedef struct packed {
    addr_t  addr;
    instr_t data;
  } parcel_t;

  // one if/id entry, instr already expanded
  typedef struct packed {
    addr_t  pc;
    instr_t instr;
    logic   is_compressed;
    logic   illegal_c;
  } if_id_t;

endpackage

/* design/fetch_top.sv */
`timescale 1ns/100ps

module fetch_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_en_i,
  // controller side
  input  fetch_pkg::redirect_t redirect_i,
  input  fetch_pkg::trap_cfg_t trap_cfg_i,
  // instruction memory
  output logic                 instr_req_o,
  output fetch_pkg::addr_t     instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  fetch_pkg::instr_t    instr_rdata_i,
  // decode side
  output logic                 instr_valid_o,
  output fetch_pkg::if_id_t    if_id_o,
  input  logic                 id_ready_i
);
  import fetch_pkg::*;

  logic    branch_req;
  addr_t   next_pc;
  parcel_t parcel;
  logic    parcel_valid;
  logic    parcel_ready;
  instr_t  exp_instr;
  logic    exp_compressed;
  logic    exp_illegal;

  // fsm, parcel acceptance and if/id register
  if_control if_control_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_en_i       (fetch_en_i),
    .pc_set_i         (redirect_i.pc_set),
    .branch_req_o     (branch_req),
    .parcel_i         (parcel),
    .parcel_valid_i   (parcel_valid),
    .parcel_ready_o   (parcel_ready),
    .exp_instr_i      (exp_instr),
    .exp_compressed_i (exp_compressed),
    .exp_illegal_i    (exp_illegal),
    .instr_valid_o    (instr_valid_o),
    .if_id_o          (if_id_o),
    .id_ready_i       (id_ready_i)
  );

  pc_select pc_select_i (
    .redirect_i (redirect_i),
    .trap_cfg_i (trap_cfg_i),
    .next_pc_o  (next_pc)
  );

  // word fetch, response queue and parcel alignment
  prefetch_buffer prefetch_buffer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch_req),
    .branch_addr_i  (next_pc),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .parcel_o       (parcel),
    .parcel_valid_o (parcel_valid),
    .parcel_ready_i (parcel_ready)
  );

  rvc_expander rvc_expander_i (
    .instr_i         (parcel.data),
    .instr_o         (exp_instr),
    .is_compressed_o (exp_compressed),
    .illegal_o       (exp_illegal)
  );

endmodule

/* design/if_control.sv */
`timescale 1ns/100ps

module if_control (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_en_i,
  input  logic               pc_set_i,
  // towards prefetch_buffer
  output logic               branch_req_o,
  input  fetch_pkg::parcel_t parcel_i,
  input  logic               parcel_valid_i,
  output logic               parcel_ready_o,
  // from rvc_expander
  input  fetch_pkg::instr_t  exp_instr_i,
  input  logic               exp_compressed_i,
  input  logic               exp_illegal_i,
  // towards decode
  output logic               instr_valid_o,
  output fetch_pkg::if_id_t  if_id_o,
  input  logic               id_ready_i
);
  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_n;
  logic         load;

  // ------------------------------
  // fetch fsm
  // ------------------------------
  always_comb begin
    state_n      = state_q;
    branch_req_o = 1'b0;
    unique case (state_q)
      // wait for the core to enable fetching
      FS_IDLE: begin
        if (fetch_en_i) begin
          branch_req_o = 1'b1;
          state_n      = FS_RUN;
        end
      end
      FS_RUN: begin
        state_n = FS_RUN;
      end
      default: begin
        state_n = FS_IDLE;
      end
    endcase
    // redirect restarts the buffer at the new pc
    if (pc_set_i) begin
      branch_req_o = 1'b1;
      state_n      = FS_RUN;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FS_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  // ------------------------------
  // if/id register
  // ------------------------------
  // room when empty or when decode drains the entry this cycle
  assign parcel_ready_o = ~instr_valid_o | id_ready_i;
  // parcel in a redirect cycle belongs to the old stream
  assign load = parcel_valid_i & parcel_ready_o & ~pc_set_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_o <= 1'b0;
    end else if (pc_set_i) begin
      instr_valid_o <= 1'b0;
    end else if (load) begin
      instr_valid_o <= 1'b1;
    end else if (id_ready_i) begin
      // taken by decode with nothing behind it
      instr_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      if_id_o.pc            <= parcel_i.addr;
      if_id_o.instr         <= exp_instr_i;
      if_id_o.is_compressed <= exp_compressed_i;
      if_id_o.illegal_c     <= exp_illegal_i;
    end
  end

endmodule

/* design/pc_select.sv */
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module pc_select (
  input  fetch_pkg::redirect_t redirect_i,
  input  fetch_pkg::trap_cfg_t trap_cfg_i,
  output fetch_pkg::addr_t     next_pc_o
);
  import fetch_pkg::*;

  localparam addr_t BOOT_PC = `FETCH_BOOT_ADDR;

  addr_t exc_pc;

  // ------------------------------
  // exception vector
  // ------------------------------
  always_comb begin
    unique case (redirect_i.exc_sel)
      // vectored entry, 4 bytes per interrupt line
      EXC_IRQ:   exc_pc = {trap_cfg_i.trap_base, 1'b0, redirect_i.irq_id, 2'b00};
      EXC_DEBUG: exc_pc = {trap_cfg_i.dm_halt_addr, 2'b00};
      // all synchronous traps share the table base
      default:   exc_pc = {trap_cfg_i.trap_base, 8'h00};
    endcase
  end

  // ------------------------------
  // next pc mux
  // ------------------------------
  always_comb begin
    // no pc_set means start-up, fetch from boot
    next_pc_o = BOOT_PC;
    if (redirect_i.pc_set) begin
      unique case (redirect_i.pc_sel)
        // halfword alignment is all the core needs
        PC_JUMP:      next_pc_o = {redirect_i.jump_target[31:1], 1'b0};
        PC_BRANCH:    next_pc_o = {redirect_i.branch_target[31:1], 1'b0};
        PC_EXCEPTION: next_pc_o = exc_pc;
        // return from trap handler
        PC_MRET:      next_pc_o = {redirect_i.mepc[31:1], 1'b0};
        // leave debug mode
        PC_DRET:      next_pc_o = {redirect_i.depc[31:1], 1'b0};
        default:      next_pc_o = BOOT_PC;
      endcase
    end
  end

endmodule

/* design/prefetch_buffer.sv */
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module prefetch_buffer (
  input  logic               clk,
  input  logic               rst_n,
  // redirect from if_control
  input  logic               branch_i,
  input  fetch_pkg::addr_t   branch_addr_i,
  // instruction memory port
  output logic               instr_req_o,
  output fetch_pkg::addr_t   instr_addr_o,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  fetch_pkg::instr_t  instr_rdata_i,
  // parcel towards if_control
  output fetch_pkg::parcel_t parcel_o,
  output logic               parcel_valid_o,
  input  logic               parcel_ready_i
);
  import fetch_pkg::*;

  localparam int unsigned DEPTH   = `FETCH_QUEUE_DEPTH;
  localparam int unsigned MAX_OUT = `FETCH_MAX_OUTSTANDING;
  localparam int unsigned PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W   = $clog2(DEPTH + 1);

  logic             active_q;
  addr_t            fetch_addr_q;
  // bit 1 of the parcel pc is the halfword offset into the head word
  addr_t            pc_q;
  logic [CNT_W-1:0] out_cnt_q;
  logic [CNT_W-1:0] out_cnt_n;
  logic [CNT_W-1:0] discard_q;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W:0]   in_use;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_nxt;
  logic [PTR_W-1:0] wr_ptr_nxt;
  instr_t           words_q [DEPTH];
  instr_t           w0;
  instr_t           w1;
  logic             room;
  logic             req_gnt;
  logic             push;
  logic             pop;
  logic             consume;
  logic             is_c;

  // ------------------------------
  // memory request side
  // ------------------------------
  // queued words plus responses in flight must fit the queue
  assign in_use  = cnt_q + out_cnt_q;
  assign room    = (in_use < (CNT_W+1)'(DEPTH)) && (out_cnt_q < CNT_W'(MAX_OUT));

  assign instr_req_o  = active_q & room;
  assign instr_addr_o = fetch_addr_q;
  assign req_gnt      = instr_req_o & instr_gnt_i;

  // every grant gets one rvalid, in order
  assign out_cnt_n = out_cnt_q + CNT_W'(req_gnt) - CNT_W'(instr_rvalid_i);

  // responses from before a redirect never reach the queue
  assign push = instr_rvalid_i & (discard_q == '0) & ~branch_i;

  // ------------------------------
  // parcel alignment
  // ------------------------------
  assign rd_ptr_nxt = (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
  assign wr_ptr_nxt = (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
  assign w0 = words_q[rd_ptr_q];
  assign w1 = words_q[rd_ptr_nxt];

  always_comb begin
    parcel_o.addr = pc_q;
    // misaligned parcel spans the upper half of w0 and the lower half of w1
    parcel_o.data = pc_q[1] ? {w1[15:0], w0[31:16]} : w0;
  end

  assign is_c = (parcel_o.data[1:0] != 2'b11);

  // a misaligned 32-bit parcel needs a second word
  assign parcel_valid_o = (cnt_q != '0) && (is_c || !pc_q[1] || (cnt_q > CNT_W'(1)));

  assign consume = parcel_valid_o & parcel_ready_i & ~branch_i;
  // head word stays only for a compressed parcel in its lower half
  assign pop     = consume & (pc_q[1] | ~is_c);

  // ------------------------------
  // control state
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      fetch_addr_q <= '0;
      pc_q         <= '0;
      out_cnt_q    <= '0;
      discard_q    <= '0;
      cnt_q        <= '0;
      rd_ptr_q     <= '0;
      wr_ptr_q     <= '0;
    end else begin
      out_cnt_q <= out_cnt_n;
      if (branch_i) begin
        active_q     <= 1'b1;
        fetch_addr_q <= {branch_addr_i[31:2], 2'b00};
        pc_q         <= {branch_addr_i[31:1], 1'b0};
        // whatever is still in flight after this edge is stale
        discard_q    <= out_cnt_n;
        cnt_q        <= '0;
        rd_ptr_q     <= '0;
        wr_ptr_q     <= '0;
      end else begin
        if (req_gnt) begin
          fetch_addr_q <= fetch_addr_q + 32'd4;
        end
        if (instr_rvalid_i && (discard_q != '0)) begin
          discard_q <= discard_q - 1'b1;
        end
        if (push) begin
          wr_ptr_q <= wr_ptr_nxt;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_nxt;
        end
        if (consume) begin
          pc_q <= pc_q + (is_c ? 32'd2 : 32'd4);
        end
        cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
      end
    end
  end

  // word storage
  always_ff @(posedge clk) begin
    if (push) begin
      words_q[wr_ptr_q] <= instr_rdata_i;
    end
  end

endmodule

/* design/rvc_expander.sv */
`timescale 1ns/100ps

module rvc_expander (
  input  fetch_pkg::instr_t instr_i,
  output fetch_pkg::instr_t instr_o,
  output logic              is_compressed_o,
  output logic              illegal_o
);

  // base opcodes used by the expansions
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  logic [15:0] c;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  // 3-bit register fields map onto x8..x15
  logic [4:0]  rdp;
  logic [4:0]  rs1p;

  assign c    = instr_i[15:0];
  assign rd   = c[11:7];
  assign rs2  = c[6:2];
  assign rdp  = {2'b01, c[4:2]};
  assign rs1p = {2'b01, c[9:7]};

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    // illegal paths leave the expansion at zero
    instr_o   = '0;
    illegal_o = 1'b0;
    unique case (c[1:0])
      // ------------------------------
      // quadrant 0
      // ------------------------------
      2'b00: begin
        unique case (c[15:13])
          // c.lw, word offset scaled by 4
          3'b010:  instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1p, 3'b010, rdp, OPC_LOAD};
          // c.sw, rs2' sits where rd' is for c.lw
          3'b110:  instr_o = {5'b0, c[5], c[12], rdp, rs1p, 3'b010, c[11:10], c[6], 2'b00,
                              OPC_STORE};
          default: illegal_o = 1'b1;
        endcase
      end
      // ------------------------------
      // quadrant 1
      // ------------------------------
      2'b01: begin
        unique case (c[15:13])
          // c.addi, c.nop is the rd=0 imm=0 case
          3'b000: instr_o = {{7{c[12]}}, c[6:2], rd, 3'b000, rd, OPC_OPIMM};
          // c.jal links x1, c.j links x0
          3'b001, 3'b101: begin
            instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], c[12],
                       {8{c[12]}}, (c[15] ? 5'd0 : 5'd1), OPC_JAL};
          end
          // c.li
          3'b010: instr_o = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd, OPC_OPIMM};
          3'b011: begin
            // rd=2 is c.addi16sp, not supported
            if ((rd == 5'd2) || ({c[12], c[6:2]} == 6'd0)) begin
              illegal_o = 1'b1;
            end else begin
              instr_o = {{15{c[12]}}, c[6:2], rd, OPC_LUI};
            end
          end
          // c.beqz / c.bnez, funct3 lsb picks bne
          3'b110, 3'b111: begin
            instr_o = {{4{c[12]}}, c[6:5], c[2], 5'd0, rs1p, 2'b00, c[13], c[11:10], c[4:3],
                       c[12], OPC_BRANCH};
          end
          // alu ops are outside the supported set
          default: illegal_o = 1'b1;
        endcase
      end
      // ------------------------------
      // quadrant 2
      // ------------------------------
      2'b10: begin
        if (c[15:13] == 3'b100) begin
          if (rs2 == 5'd0) begin
            // c.jr / c.jalr, rs1=0 is reserved or c.ebreak
            if (rd == 5'd0) begin
              illegal_o = 1'b1;
            end else begin
              instr_o = {12'd0, rd, 3'b000, {4'd0, c[12]}, OPC_JALR};
            end
          end else if (c[12]) begin
            // c.add
            instr_o = {7'd0, rs2, rd, 3'b000, rd, OPC_OP};
          end else begin
            // c.mv
            instr_o = {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP};
          end
        end else begin
          illegal_o = 1'b1;
        end
      end
      // full 32-bit encoding passes through
      default: instr_o = instr_i;
    endcase
  end

endmodule

/* include/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// reset pc, must be word aligned
`define FETCH_BOOT_ADDR 32'h0000_0080

// words held by the prefetch queue
`define FETCH_QUEUE_DEPTH 4

// granted requests still waiting for rvalid
// keep this at or below the queue depth
`define FETCH_MAX_OUTSTANDING 2

`endif

/* verilog.f */
+incdir+include
design/fetch_pkg.sv
design/pc_select.sv
design/prefetch_buffer.sv
design/rvc_expander.sv
design/if_control.sv
design/fetch_top.sv
bench/fetch_mem_model.sv
bench/fetch_tb.sv
